//--- source/decodePkg.sv
`default_nettype none

package decodePkg;

  localparam int xlen = 32;
  localparam int regAddrW = 5;

  // RV32 major opcodes
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opOp     = 7'b0110011;
  localparam logic [6:0] opOpImm  = 7'b0010011;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opJalr   = 7'b1100111;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opAmo    = 7'b0101111;

  // Bits 31..27 of an AMO word
  localparam logic [4:0] funct5Lr = 5'b00010;
  localparam logic [4:0] funct5Sc = 5'b00011;

  // Coarse ALU class fed to aluControl
  typedef enum logic [2:0] {
    memAddr     = 3'b000,
    branchCmp   = 3'b001,
    regOp       = 3'b010,
    linkOrUpper = 3'b011,
    amo         = 3'b100,
    immOp       = 3'b110,
    none        = 3'b111
  } aluClassT;

  typedef enum logic [3:0] {
    add,
    sub,
    sll,
    slt,
    sltu,
    xorOp,
    srl,
    sra,
    orOp,
    andOp,
    passB    // Link path in execute
  } aluFuncT;

  typedef struct packed {
    logic     branch;
    logic     memRead;
    logic     memWrite;
    logic     memToReg;
    logic     aluSrc;
    logic     pcToAlu;
    logic     zeroToAlu;
    logic     regWrite;
    logic     byteLoad;
    logic     halfLoad;
    logic     unsignedLoad;
    logic     illegal;
    aluClassT aluClass;
    aluFuncT  aluFunc;
  } ctrlT;

endpackage

`default_nettype wire

//--- source/regPortIf.sv
`timescale 1ns/1ps
`default_nettype none

interface regPortIf import decodePkg::*; ();

  logic [regAddrW-1:0] rs1Addr;
  logic [regAddrW-1:0] rs2Addr;
  logic [xlen-1:0]     rs1Data;
  logic [xlen-1:0]     rs2Data;
  logic                wrEn;
  logic [regAddrW-1:0] wrAddr;
  logic [xlen-1:0]     wrData;

  modport stage (
    output rs1Addr, rs2Addr,
    output wrEn, wrAddr, wrData,
    input  rs1Data, rs2Data
  );

  modport file (
    input  rs1Addr, rs2Addr,
    input  wrEn, wrAddr, wrData,
    output rs1Data, rs2Data
  );

endinterface

`default_nettype wire

//--- source/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit import decodePkg::*; (
  input  logic [31:0] instr,
  output ctrlT        ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [4:0] funct5;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct5 = instr[31:27];

  always_comb begin
    ctrl          = '0;
    ctrl.aluClass = none;
    ctrl.aluFunc  = add;    // Replaced by the ALU control output
    case (opcode)
      opLoad: begin
        ctrl.memRead      = 1'b1;
        ctrl.memToReg     = 1'b1;
        ctrl.aluSrc       = 1'b1;
        ctrl.regWrite     = 1'b1;
        ctrl.aluClass     = memAddr;
        ctrl.byteLoad     = (funct3 == 3'b000) || (funct3 == 3'b100);
        ctrl.halfLoad     = (funct3 == 3'b001) || (funct3 == 3'b101);
        ctrl.unsignedLoad = (funct3 == 3'b100) || (funct3 == 3'b101);
      end
      opStore: begin
        ctrl.memWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluClass = memAddr;
      end
      opBranch: begin
        ctrl.branch   = 1'b1;
        ctrl.aluClass = branchCmp;
      end
      opOp: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluClass = regOp;
      end
      opOpImm: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluClass = immOp;
      end
      opJal, opJalr: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluClass = linkOrUpper;
      end
      opLui: begin
        ctrl.aluSrc    = 1'b1;
        ctrl.regWrite  = 1'b1;
        ctrl.zeroToAlu = 1'b1;    // 0 + imm
        ctrl.aluClass  = linkOrUpper;
      end
      opAuipc: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.pcToAlu  = 1'b1;     // pc + imm
        ctrl.aluClass = linkOrUpper;
      end
      opAmo: begin
        ctrl.aluClass = amo;
        if (funct5 == funct5Lr) begin
          ctrl.memRead  = 1'b1;   // Word access, no width flags
          ctrl.memToReg = 1'b1;
          ctrl.regWrite = 1'b1;
        end else if (funct5 == funct5Sc) begin
          ctrl.memWrite = 1'b1;
          ctrl.regWrite = 1'b1;   // Success code into rd
        end else begin
          ctrl.illegal = 1'b1;    // Other AMOs unsupported
        end
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- source/aluControl.sv
`timescale 1ns/1ps
`default_nettype none

module aluControl import decodePkg::*; (
  input  aluClassT   aluClass,
  input  logic [2:0] funct3,
  input  logic       funct7b5,
  output aluFuncT    aluFunc
);

  logic isImm;

  assign isImm = (aluClass == immOp);   // No sub form for immediates

  always_comb begin
    aluFunc = add;
    case (aluClass)
      branchCmp: aluFunc = sub;
      regOp, immOp: begin
        case (funct3)
          3'b000: begin
            if (funct7b5 && !isImm) begin
              aluFunc = sub;
            end else begin
              aluFunc = add;
            end
          end
          3'b001: aluFunc = sll;
          3'b010: aluFunc = slt;
          3'b011: aluFunc = sltu;
          3'b100: aluFunc = xorOp;
          3'b101: begin
            if (funct7b5) begin
              aluFunc = sra;      // SRA and SRAI
            end else begin
              aluFunc = srl;
            end
          end
          3'b110: aluFunc = orOp;
          default: aluFunc = andOp;
        endcase
      end
      // memAddr, linkOrUpper, amo and none add
      default: aluFunc = add;
    endcase
  end

endmodule

`default_nettype wire

//--- source/immGen.sv
`timescale 1ns/1ps
`default_nettype none

module immGen import decodePkg::*; (
  input  logic [31:0]     instr,
  output logic [xlen-1:0] imm
);

  logic [6:0] opcode;
  logic       sign;

  assign opcode = instr[6:0];
  assign sign   = instr[31];

  always_comb begin
    case (opcode)
      opLoad, opOpImm, opJalr: begin
        imm = {{20{sign}}, instr[31:20]};    // I type
      end
      opStore: begin
        imm = {{20{sign}}, instr[31:25], instr[11:7]};
      end
      opBranch: begin
        imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      opLui, opAuipc: begin
        imm = {instr[31:12], 12'b0};         // U type
      end
      opJal: begin
        imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: imm = '0;                     // AMO and unknown
    endcase
  end

endmodule

`default_nettype wire

//--- source/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import decodePkg::*; (
  input logic    clk,
  input logic    rstN,
  regPortIf.file port
);

  logic [xlen-1:0] regs [32];

  // Bypass lets a same-cycle write reach the reader
  function automatic logic [xlen-1:0] readReg(input logic [regAddrW-1:0] addr);
    logic [xlen-1:0] value;
    if (addr == '0) begin
      value = '0;
    end else if (port.wrEn && (port.wrAddr == addr)) begin
      value = port.wrData;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (port.wrEn && (port.wrAddr != '0)) begin
      regs[port.wrAddr] <= port.wrData;   // x0 writes dropped
    end
  end

  always_comb begin
    port.rs1Data = readReg(port.rs1Addr);
    port.rs2Data = readReg(port.rs2Addr);
  end

  // Storage of x0 never picks up a write
  x0Zero: assert property (@(posedge clk) regs[0] == '0)
    else $error("regFile x0 storage not zero");

endmodule

`default_nettype wire

//--- source/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage import decodePkg::*; (
  input  logic                clk,
  input  logic                rstN,

  input  logic                inValid,
  output logic                inReady,
  input  logic [31:0]         inInstr,
  input  logic [xlen-1:0]     inPc,

  input  logic                wbEn,
  input  logic [regAddrW-1:0] wbRd,
  input  logic [xlen-1:0]     wbData,

  output logic                outValid,
  input  logic                outReady,
  output logic [xlen-1:0]     outPc,
  output logic [regAddrW-1:0] outRd,
  output logic [xlen-1:0]     outRs1Data,
  output logic [xlen-1:0]     outRs2Data,
  output logic [xlen-1:0]     outImm,
  output logic [2:0]          outFunct3,
  output ctrlT                outCtrl
);

  regPortIf rf ();

  ctrlT            ctrlRaw;
  ctrlT            ctrlFull;
  aluFuncT         aluFunc;
  logic [xlen-1:0] imm;
  logic            accept;

  // Read addresses straight from the incoming word
  assign rf.rs1Addr = inInstr[19:15];
  assign rf.rs2Addr = inInstr[24:20];
  assign rf.wrEn    = wbEn;
  assign rf.wrAddr  = wbRd;
  assign rf.wrData  = wbData;

  controlUnit uControl (
    .instr (inInstr),
    .ctrl  (ctrlRaw)
  );

  aluControl uAluControl (
    .aluClass (ctrlRaw.aluClass),
    .funct3   (inInstr[14:12]),
    .funct7b5 (inInstr[30]),
    .aluFunc  (aluFunc)
  );

  immGen uImmGen (
    .instr (inInstr),
    .imm   (imm)
  );

  regFile uRegFile (
    .clk  (clk),
    .rstN (rstN),
    .port (rf.file)
  );

  always_comb begin
    ctrlFull         = ctrlRaw;
    ctrlFull.aluFunc = aluFunc;
  end

  assign inReady = !outValid || outReady;   // Slot empty or draining
  assign accept  = inValid && inReady;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else if (accept) begin
      outValid <= 1'b1;
    end else if (outReady) begin
      outValid <= 1'b0;
    end
  end

  // Payload only moves on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      outPc      <= inPc;
      outRd      <= inInstr[11:7];
      outFunct3  <= inInstr[14:12];
      outRs1Data <= rf.rs1Data;
      outRs2Data <= rf.rs2Data;
      outImm     <= imm;
      outCtrl    <= ctrlFull;
    end
  end

  holdStable: assert property (
    @(posedge clk) disable iff (!rstN)
    outValid && !outReady |=> outValid && $stable(outPc) && $stable(outRd)
      && $stable(outRs1Data) && $stable(outRs2Data) && $stable(outImm)
      && $stable(outFunct3) && $stable(outCtrl)
  ) else $error("decodeStage output changed while stalled");

endmodule

`default_nettype wire

//--- sim/decodeChecker.sv
`timescale 1ns/1ps
`default_nettype none

module decodeChecker import decodePkg::*; (
  input  logic                clk,
  input  logic                rstN,
  input  logic                inValid,
  input  logic                inReady,
  input  logic [31:0]         inInstr,
  input  logic [xlen-1:0]     inPc,
  input  logic                wbEn,
  input  logic [regAddrW-1:0] wbRd,
  input  logic [xlen-1:0]     wbData,
  input  logic                outValid,
  input  logic                outReady,
  input  logic [xlen-1:0]     outPc,
  input  logic [regAddrW-1:0] outRd,
  input  logic [xlen-1:0]     outRs1Data,
  input  logic [xlen-1:0]     outRs2Data,
  input  logic [xlen-1:0]     outImm,
  input  logic [2:0]          outFunct3,
  input  ctrlT                outCtrl,
  output int                  mismatchCount,
  output int                  otherCount,
  output int                  pendingCount
);

  typedef struct packed {
    ctrlT                ctrl;
    logic [xlen-1:0]     imm;
    logic [xlen-1:0]     rs1Data;
    logic [xlen-1:0]     rs2Data;
    logic [xlen-1:0]     pc;
    logic [regAddrW-1:0] rd;
    logic [2:0]          funct3;
  } expectT;

  logic [xlen-1:0] model [32];    // Shadow register file
  expectT          expected [$];  // Accepted, not yet drained
  expectT          held;
  logic            heldValid = 1'b0;
  logic            acceptedLast = 1'b0;
  logic [xlen-1:0] lastPc;
  int              mismatches = 0;
  int              others = 0;
  int              pending = 0;

  assign mismatchCount = mismatches;
  assign otherCount    = others;
  assign pendingCount  = pending;

  function automatic aluFuncT funcFromFunct3(input logic [2:0] f3, input logic b5,
                                             input logic allowSub);
    case (f3)
      3'd0: return (allowSub && b5) ? sub : add;
      3'd1: return sll;
      3'd2: return slt;
      3'd3: return sltu;
      3'd4: return xorOp;
      3'd5: return b5 ? sra : srl;
      3'd6: return orOp;
      default: return andOp;
    endcase
  endfunction

  function automatic ctrlT expectCtrl(input logic [31:0] w);
    ctrlT       c;
    logic [2:0] f3;
    logic       isLoad, isStore, isBranch, isOp, isImm, isLink, isUpper, isLr, isSc;
    f3       = w[14:12];
    isLoad   = (w[6:0] == opLoad);
    isStore  = (w[6:0] == opStore);
    isBranch = (w[6:0] == opBranch);
    isOp     = (w[6:0] == opOp);
    isImm    = (w[6:0] == opOpImm);
    isLink   = (w[6:0] == opJal) || (w[6:0] == opJalr);
    isUpper  = (w[6:0] == opLui) || (w[6:0] == opAuipc);
    isLr     = (w[6:0] == opAmo) && (w[31:27] == funct5Lr);
    isSc     = (w[6:0] == opAmo) && (w[31:27] == funct5Sc);
    c              = '0;
    c.branch       = isBranch;
    c.memRead      = isLoad || isLr;
    c.memWrite     = isStore || isSc;
    c.memToReg     = isLoad || isLr;
    c.aluSrc       = isLoad || isStore || isImm || isLink || isUpper;
    c.pcToAlu      = (w[6:0] == opAuipc);
    c.zeroToAlu    = (w[6:0] == opLui);
    c.regWrite     = isLoad || isOp || isImm || isLink || isUpper || isLr || isSc;
    c.byteLoad     = isLoad && (f3[1:0] == 2'b00);
    c.halfLoad     = isLoad && (f3[1:0] == 2'b01);
    c.unsignedLoad = isLoad && f3[2] && !f3[1];
    c.illegal      = !(isLoad || isStore || isBranch || isOp || isImm || isLink || isUpper
                       || isLr || isSc);
    if (isLoad || isStore) c.aluClass = memAddr;
    else if (isBranch) c.aluClass = branchCmp;
    else if (isOp) c.aluClass = regOp;
    else if (isImm) c.aluClass = immOp;
    else if (isLink || isUpper) c.aluClass = linkOrUpper;
    else if (w[6:0] == opAmo) c.aluClass = amo;    // Also for unsupported AMOs
    else c.aluClass = none;
    if (isOp) c.aluFunc = funcFromFunct3(f3, w[30], 1'b1);
    else if (isImm) c.aluFunc = funcFromFunct3(f3, w[30], 1'b0);
    else if (isBranch) c.aluFunc = sub;
    else c.aluFunc = add;
    return c;
  endfunction

  // Field placed at the top, then shifted down arithmetically
  function automatic logic [xlen-1:0] expectImm(input logic [31:0] w);
    logic signed [31:0] t;
    t = '0;
    if (w[6:0] == opLoad || w[6:0] == opOpImm || w[6:0] == opJalr) begin
      t = $signed(w) >>> 20;
    end else if (w[6:0] == opStore) begin
      t = {w[31:25], w[11:7], 20'b0};
      t = t >>> 20;
    end else if (w[6:0] == opBranch) begin
      t = {w[31], w[7], w[30:25], w[11:8], 1'b0, 19'b0};
      t = t >>> 19;
    end else if (w[6:0] == opLui || w[6:0] == opAuipc) begin
      t = {w[31:12], 12'b0};
    end else if (w[6:0] == opJal) begin
      t = {w[31], w[19:12], w[20], w[30:21], 1'b0, 11'b0};
      t = t >>> 11;
    end
    return t;
  endfunction

  function automatic logic [xlen-1:0] readModel(input logic [regAddrW-1:0] addr);
    if (addr == '0) return '0;
    if (wbEn && wbRd == addr) return wbData;    // Same-cycle write wins
    return model[addr];
  endfunction

  task automatic checkField(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic compareOut(input expectT e);
    checkField("outPc", e.pc, outPc);
    checkField("outRd", 32'(e.rd), 32'(outRd));
    checkField("outFunct3", 32'(e.funct3), 32'(outFunct3));
    checkField("outRs1Data", e.rs1Data, outRs1Data);
    checkField("outRs2Data", e.rs2Data, outRs2Data);
    checkField("outImm", e.imm, outImm);
    checkField("outCtrl", 32'(e.ctrl), 32'(outCtrl));
  endtask

  always @(posedge clk) begin
    expectT e;
    logic   slotFull;
    if (!rstN) begin
      for (int i = 0; i < 32; i++) begin
        model[i] = '0;
      end
      expected.delete();
      heldValid    = 1'b0;
      acceptedLast = 1'b0;
      if (outValid !== 1'b0) begin
        others++;
        $display("outValid is not low during reset");
      end
    end else begin
      slotFull = (expected.size() != 0);    // One-entry output slot
      if (outValid !== slotFull) begin
        others++;
        $display("outValid does not match the number of pending instructions");
      end
      if (inReady !== (!slotFull || outReady)) begin
        others++;
        $display("inReady does not follow the output slot state");
      end
      if (acceptedLast && (outValid !== 1'b1 || outPc !== lastPc)) begin
        others++;
        $display("Accepted instruction at pc %h missing one cycle later", lastPc);
      end
      if (heldValid) begin
        if (outValid !== 1'b1) begin
          others++;
          $display("outValid dropped while the output was stalled");
        end
        compareOut(held);    // Stalled slot must not move
      end
      if (outValid && outReady) begin
        if (expected.size() == 0) begin
          others++;
          $display("Output transfer with no instruction pending");
        end else begin
          compareOut(expected.pop_front());
        end
      end
      acceptedLast = inValid && inReady;
      if (acceptedLast) begin
        e.ctrl    = expectCtrl(inInstr);
        e.imm     = expectImm(inInstr);
        e.rs1Data = readModel(inInstr[19:15]);
        e.rs2Data = readModel(inInstr[24:20]);
        e.pc      = inPc;
        e.rd      = inInstr[11:7];
        e.funct3  = inInstr[14:12];
        expected.push_back(e);
        lastPc = inPc;
      end
      if (wbEn && wbRd != '0) begin
        model[wbRd] = wbData;
      end
      heldValid      = outValid && !outReady;
      held.pc        = outPc;
      held.rd        = outRd;
      held.funct3    = outFunct3;
      held.rs1Data   = outRs1Data;
      held.rs2Data   = outRs2Data;
      held.imm       = outImm;
      held.ctrl      = outCtrl;
    end
    pending = expected.size();
  end

endmodule

`default_nettype wire

//--- sim/decodeTb.sv
`timescale 1ns/1ps
`default_nettype none

module decodeTb import decodePkg::*; ();

  localparam int clkHalf     = 20;
  localparam int resetCycles = 16;
  localparam int driveDelay  = 2;
  localparam int numInstr    = 3000;
  localparam int burstLen    = 40;      // Full-rate phase first

  logic                clk = 1'b0;
  logic                rstN;
  logic                inValid;
  logic                inReady;
  logic [31:0]         inInstr;
  logic [xlen-1:0]     inPc;
  logic                wbEn;
  logic [regAddrW-1:0] wbRd;
  logic [xlen-1:0]     wbData;
  logic                outValid;
  logic                outReady;
  logic [xlen-1:0]     outPc;
  logic [regAddrW-1:0] outRd;
  logic [xlen-1:0]     outRs1Data;
  logic [xlen-1:0]     outRs2Data;
  logic [xlen-1:0]     outImm;
  logic [2:0]          outFunct3;
  ctrlT                outCtrl;
  int                  mismatchCount;
  int                  otherCount;
  int                  pendingCount;
  int                  tbErrors = 0;
  int                  accepted = 0;
  logic                taken = 1'b0;     // Transfer due at the next edge

  logic [6:0] legalOps [10] = '{opLoad, opStore, opBranch, opOp, opOpImm,
                                opJal, opJalr, opLui, opAuipc, opAmo};

  always #(clkHalf) clk = ~clk;

  decodeStage i_dut (.*);

  decodeChecker uChecker (.*);

  function automatic logic isLegalOp(input logic [6:0] op);
    for (int i = 0; i < 10; i++) begin
      if (legalOps[i] == op) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic makeInstr(output logic [31:0] word);
    logic [31:0] r;
    logic [31:0] pick;
    logic [6:0]  op;
    r    = $urandom;
    pick = $urandom;
    if (pick % 12 == 0) begin
      do begin
        pick = $urandom;
        op   = pick[6:0];
      end while (isLegalOp(op));    // Some other 7-bit value
    end else begin
      op = legalOps[int'(pick % 10)];
    end
    word = {r[31:7], op};
    if (op == opAmo) begin
      pick = $urandom % 3;
      if (pick == 0) begin
        word[31:27] = funct5Lr;
      end else if (pick == 1) begin
        word[31:27] = funct5Sc;
      end
    end
  endtask

  task automatic driveWriteback();
    logic [31:0] r;
    r      = $urandom;
    wbEn   = r[0];
    wbRd   = r[5:1];
    wbData = $urandom;
  endtask

  // Runs from just after one edge to just after the next
  task automatic stepCycle(input logic burst);
    logic [31:0] r;
    if (!inValid || taken) begin
      r = $urandom;
      if (accepted < numInstr && (burst || (r % 10) < 7)) begin
        inValid = 1'b1;
        makeInstr(inInstr);
        r    = $urandom;
        inPc = {r[31:2], 2'b00};
      end else begin
        inValid = 1'b0;
      end
    end
    r        = $urandom;
    outReady = burst || ((r % 10) < 6);
    driveWriteback();
    #1;
    taken = inValid && inReady;
    if (taken) accepted++;
    @(posedge clk);
    #(driveDelay);
  endtask

  initial begin
    void'($urandom(20390));
    rstN     = 1'b0;
    inValid  = 1'b0;
    inInstr  = '0;
    inPc     = '0;
    wbEn     = 1'b0;
    wbRd     = '0;
    wbData   = '0;
    outReady = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #(driveDelay);
    rstN = 1'b1;
    while (accepted < burstLen) stepCycle(1'b1);
    while (accepted < numInstr) stepCycle(1'b0);
    inValid  = 1'b0;
    outReady = 1'b1;
    wbEn     = 1'b0;
    @(posedge clk);
    #(driveDelay);
    while (outValid) begin
      @(posedge clk);
      #(driveDelay);
    end
    repeat (2) @(posedge clk);
    if (pendingCount != 0) begin
      tbErrors++;
      $display("%0d accepted instructions never left the stage", pendingCount);
    end
    $display("Closing report: %0d mismatches, %0d other errors",
             mismatchCount, otherCount + tbErrors);
    if (mismatchCount + otherCount + tbErrors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    repeat (resetCycles + numInstr * 4) @(posedge clk);
    $display("Watchdog expired after %0d cycles, run did not finish",
             resetCycles + numInstr * 4);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
source/decodePkg.sv
source/regPortIf.sv
source/controlUnit.sv
source/aluControl.sv
source/immGen.sv
source/regFile.sv
source/decodeStage.sv
sim/decodeChecker.sv
sim/decodeTb.sv

//--- run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f files.f --top-module decodeTb --Mdir "$OBJ" -o decodeSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/decodeSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$LOG"; then
  echo "Simulation reported failures"
  exit 1
fi

echo "Simulation passed"
exit 0
